// File: detect_counter.sv
module detect_counter import pm_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic sum_valid,
	input  logic sum_last,
	input  row_sum_t [PAT_SIZE-1:0] row_sums,
	output logic score_valid,
	output score_t score,
	output logic frame_done,
	output count_t match_count
);

	frame_state_t state;
	score_t score_next;
	logic hit;                                  // the window being added is a detection

	always_comb begin
		score_next = '0;
		for (int r = 0; r < PAT_SIZE; r++) begin
			score_next = score_next + score_t'(row_sums[r]);
		end
	end

	assign hit = (score_next >= score_t'(DETECT_THRESHOLD));

	always_ff @(posedge clk) begin
		if (sum_valid) begin
			score <= score_next;
		end
	end

	// frame_done rides with the score of the bottom-right window
	always_ff @(posedge clk) begin
		if (rst) begin
			score_valid <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			score_valid <= sum_valid;
			frame_done <= sum_valid && sum_last;
		end
	end

	// match_count keeps the finished total until the next frame produces a score
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BETWEEN_FRAMES;
			match_count <= '0;
		end else if (sum_valid) begin
			case (state)
				BETWEEN_FRAMES: begin
					match_count <= count_t'(hit); // first score of a frame restarts the count
					if (!sum_last) begin
						state <= IN_FRAME;
					end
				end
				IN_FRAME: begin
					match_count <= match_count + count_t'(hit);
					if (sum_last) begin
						state <= BETWEEN_FRAMES;
					end
				end
				default: begin
					state <= BETWEEN_FRAMES;
				end
			endcase
		end
	end

endmodule

// File: flist.f
pm_pkg.sv
window_feed.sv
row_correlator.sv
detect_counter.sv
pattern_match_top.sv
pattern_match_asserts.sv
tb_pattern_match.sv

// File: pattern_cases.txt
# each case: expected detection count, 6 rows of 6 signed coefficients, 12 rows of 12 pixels
# all values in hex, coefficients are two's complement bytes
2a
01 01 01 01 01 01
01 01 01 01 01 01
01 01 01 01 01 01
01 01 01 01 01 01
01 01 01 01 01 01
01 01 01 01 01 01
1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e
22 22 22 22 22 22 22 22 22 22 22 22
26 26 26 26 26 26 26 26 26 26 26 26
2a 2a 2a 2a 2a 2a 2a 2a 2a 2a 2a 2a
2e 2e 2e 2e 2e 2e 2e 2e 2e 2e 2e 2e
32 32 32 32 32 32 32 32 32 32 32 32
36 36 36 36 36 36 36 36 36 36 36 36
3a 3a 3a 3a 3a 3a 3a 3a 3a 3a 3a 3a
3e 3e 3e 3e 3e 3e 3e 3e 3e 3e 3e 3e
42 42 42 42 42 42 42 42 42 42 42 42
46 46 46 46 46 46 46 46 46 46 46 46
4a 4a 4a 4a 4a 4a 4a 4a 4a 4a 4a 4a
23
02 02 02 fe fe fe
02 02 02 fe fe fe
02 02 02 fe fe fe
02 02 02 fe fe fe
02 02 02 fe fe fe
02 02 02 fe fe fe
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
00
fe fe fe 02 02 02
fe fe fe 02 02 02
fe fe fe 02 02 02
fe fe fe 02 02 02
fe fe fe 02 02 02
fe fe fe 02 02 02
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
c8 c8 c8 c8 c8 c8 0a 0a 0a 0a 0a 0a
07
00 00 00 00 00 00
00 00 00 00 00 00
00 00 00 7f 00 00
00 00 00 00 00 00
00 00 00 00 00 00
00 00 00 00 00 00
0d 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c
0c 0d 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c
0c 0c 0d 0c 0c 0c 0c 0c 0c 0c 0c 0c
0c 0c 0c 0d 0c 0c 0c 0c 0c 0c 0c 0c
0c 0c 0c 0c 0d 0c 0c 0c 0c 0c 0c 0c
0c 0c 0c 0c ff 0d 0c 0c 0c 0c 0c 0c
0c 0c 0c 0c 0c 0c 0d 0c 0c 0c 0c 0c
0c 0c 0c 0c 0c 0c 0c 0d 0c 0c 0c 0c
0c 0c 0c 0c 0c 0c 0c 0c 0d 0c 0c 0c
0c 0c 0c 0c 0c 0c 0c 0c 0c 0d 0c 0c
0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0d 0c
0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0d

// File: pattern_match_asserts.sv
module pattern_match_asserts import pm_pkg::*; (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input logic coef_wr,
	input logic score_valid,
	input logic frame_done
);

	logic [7:0] pix_cnt;                        // pixels of the current frame taken so far
	int fail_count = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pix_cnt <= '0;
		end else if (pix_valid) begin
			if (pix_cnt == 8'(IMG_COLS * IMG_ROWS - 1)) begin
				pix_cnt <= '0;                  // the last pixel puts us back between frames
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	// outputs clear on the edge that samples rst
	score_quiet_in_reset: assert property (@(posedge clk) rst |=> !score_valid)
		else begin
			$error("score_valid high while in reset");
			fail_count++;
		end

	done_with_score: assert property (@(posedge clk) disable iff (rst) frame_done |-> score_valid)
		else begin
			$error("frame_done without score_valid");
			fail_count++;
		end

	// pattern writes only before the first pixel or after the last one
	coef_between_frames: assert property (@(posedge clk) disable iff (rst)
		coef_wr |-> (pix_cnt == '0) && !pix_valid)
		else begin
			$error("coefficient write during a frame");
			fail_count++;
		end

endmodule

bind pattern_match_top pattern_match_asserts u_asserts (.*);

// File: pattern_match_top.sv
module pattern_match_top import pm_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic pix_valid,
	input  pixel_t pix_data,
	input  logic coef_wr,
	input  tap_t coef_row,
	input  tap_t coef_col,
	input  coef_t coef_data,
	output logic score_valid,
	output score_t score,
	output logic frame_done,
	output count_t match_count
);

	logic win_valid;
	logic win_last;
	pixel_t [PAT_SIZE-1:0][PAT_SIZE-1:0] win_pix;

	logic [PAT_SIZE-1:0] row_valid;             // identical timing in every correlator
	row_sum_t [PAT_SIZE-1:0] row_sums;
	logic sum_last;

	window_feed u_window_feed (
		.clk       (clk),
		.rst       (rst),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.win_valid (win_valid),
		.win_last  (win_last),
		.win_pix   (win_pix)
	);

	// one correlator per pattern row, all sharing the coefficient write bus
	for (genvar i = 0; i < PAT_SIZE; i++) begin : g_row
		row_correlator #(
			.ROW_IDX (i)
		) u_row_correlator (
			.clk       (clk),
			.rst       (rst),
			.win_valid (win_valid),
			.win_row   (win_pix[i]),
			.coef_wr   (coef_wr),
			.coef_row  (coef_row),
			.coef_col  (coef_col),
			.coef_data (coef_data),
			.sum_valid (row_valid[i]),
			.row_sum   (row_sums[i])
		);
	end

	// last-window tag follows the correlator stage
	always_ff @(posedge clk) begin
		if (rst) begin
			sum_last <= 1'b0;
		end else begin
			sum_last <= win_last;
		end
	end

	detect_counter u_detect_counter (
		.clk         (clk),
		.rst         (rst),
		.sum_valid   (row_valid[0]),
		.sum_last    (sum_last),
		.row_sums    (row_sums),
		.score_valid (score_valid),
		.score       (score),
		.frame_done  (frame_done),
		.match_count (match_count)
	);

endmodule

// File: pm_pkg.sv
package pm_pkg;

	// frame geometry, pixels arrive already filtered
	localparam int IMG_COLS = 12;
	localparam int IMG_ROWS = 12;

	localparam int PAT_SIZE = 6;                // side of the square pattern and window

	// lowest window score that counts as a detection, compared signed
	localparam int DETECT_THRESHOLD = 1572;

	// complete windows in one frame, 7 by 7 for a 12 by 12 frame
	localparam int WINDOWS_PER_FRAME = (IMG_COLS - PAT_SIZE + 1) * (IMG_ROWS - PAT_SIZE + 1);

	typedef logic [7:0] pixel_t;                // unsigned image sample
	typedef logic signed [7:0] coef_t;          // signed pattern coefficient

	// six products of 9 bit signed by 8 bit signed need 19 bits
	typedef logic signed [18:0] row_sum_t;

	// six row sums need three more bits
	typedef logic signed [21:0] score_t;

	typedef logic [5:0] count_t;                // holds up to 63 detections

	typedef logic [3:0] col_t;
	typedef logic [3:0] row_t;
	typedef logic [2:0] tap_t;                  // row or column inside the pattern

	// the detection count restarts on the first score of a frame
	typedef enum logic {
		BETWEEN_FRAMES,
		IN_FRAME
	} frame_state_t;

endpackage

// File: row_correlator.sv
module row_correlator import pm_pkg::*; #(
	parameter int ROW_IDX = 0                   // pattern row held by this instance
) (
	input  logic clk,
	input  logic rst,
	input  logic win_valid,
	input  pixel_t [PAT_SIZE-1:0] win_row,
	input  logic coef_wr,
	input  tap_t coef_row,
	input  tap_t coef_col,
	input  coef_t coef_data,
	output logic sum_valid,
	output row_sum_t row_sum
);

	coef_t coef [PAT_SIZE];                     // coefficient c multiplies win_row[c]
	logic coef_hit;
	row_sum_t sum_next;

	// only writes to this row and to a column inside the pattern are taken
	assign coef_hit = coef_wr
		&& (coef_row == tap_t'(ROW_IDX))
		&& (coef_col < tap_t'(PAT_SIZE));

	always_ff @(posedge clk) begin
		if (coef_hit) begin
			coef[coef_col] <= coef_data;
		end
	end

	// pixels are unsigned, so a zero bit in front makes them positive signed values
	always_comb begin
		sum_next = '0;
		for (int c = 0; c < PAT_SIZE; c++) begin
			sum_next = sum_next
				+ row_sum_t'($signed({1'b0, win_row[c]})) * row_sum_t'(coef[c]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= win_valid;             // one cycle behind the window
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid) begin
			row_sum <= sum_next;
		end
	end

endmodule

// File: tb_pattern_match.sv
module tb_pattern_match import pm_pkg::*; ();

	localparam int FRAME_PIX = IMG_COLS * IMG_ROWS;
	localparam int MAX_FILE_CASES = 8;
	// file frames, the random frame, the cut frame and the frame after the reset
	localparam int TOTAL_PIX = (MAX_FILE_CASES + 3) * FRAME_PIX;
	localparam int TIMEOUT_CYCLES = 4 * TOTAL_PIX + 16 + 1000;

	logic clk;
	logic rst;
	logic rst_q;                                // rst as seen by the last clock edge
	logic pix_valid;
	pixel_t pix_data;
	logic coef_wr;
	tap_t coef_row;
	tap_t coef_col;
	coef_t coef_data;
	logic score_valid;
	score_t score;
	logic frame_done;
	count_t match_count;

	int img [IMG_ROWS][IMG_COLS];
	int pat [PAT_SIZE][PAT_SIZE];
	int exp_score_q [$];
	int exp_cycle_q [$];
	bit exp_last_q [$];
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int cases_run = 0;
	int frames_done = 0;
	int scores_seen = 0;
	int done_scores = 0;
	int done_count = 0;
	bit first_score_seen = 1'b0;
	integer seed;
	int fd;

	pattern_match_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.pix_valid   (pix_valid),
		.pix_data    (pix_data),
		.coef_wr     (coef_wr),
		.coef_row    (coef_row),
		.coef_col    (coef_col),
		.coef_data   (coef_data),
		.score_valid (score_valid),
		.score       (score),
		.frame_done  (frame_done),
		.match_count (match_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		rst_q <= rst;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("timeout: the DUT did not finish its frames within %0d cycles", cyc);
			$display("Something failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic signed [63:0] got,
			input logic signed [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// straight sum of pixel times coefficient over one 6x6 window
	function automatic int window_score(input int top, input int left);
		int sum;
		sum = 0;
		for (int r = 0; r < PAT_SIZE; r++) begin
			for (int c = 0; c < PAT_SIZE; c++) begin
				sum += img[top+r][left+c] * pat[r][c];
			end
		end
		return sum;
	endfunction

	function automatic int model_count();
		int n;
		n = 0;
		for (int t = 0; t <= IMG_ROWS - PAT_SIZE; t++) begin
			for (int l = 0; l <= IMG_COLS - PAT_SIZE; l++) begin
				if (window_score(t, l) >= DETECT_THRESHOLD) n++;
			end
		end
		return n;
	endfunction

	// returns the next hex value in the case file and skips lines starting with #
	task automatic read_token(output int val, output bit ok);
		string tok;
		string rest;
		int n;
		ok = 1'b0;
		val = 0;
		while (!ok) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1) return;
			if (tok[0] == "#") begin
				n = $fgets(rest, fd);
			end else begin
				n = $sscanf(tok, "%h", val);
				ok = 1'b1;
			end
		end
	endtask

	task automatic read_case(output int expected, output bit ok);
		int v;
		bit got;
		read_token(expected, ok);
		if (!ok) return;
		for (int i = 0; i < PAT_SIZE * PAT_SIZE + FRAME_PIX; i++) begin
			read_token(v, got);
			if (!got) begin
				$display("pattern_cases.txt ends part-way through a case");
				errors++;
				ok = 1'b0;
				return;
			end
			if (i < PAT_SIZE * PAT_SIZE) pat[i / PAT_SIZE][i % PAT_SIZE] = (v > 127) ? v - 256 : v;
			else img[(i - 36) / IMG_COLS][(i - 36) % IMG_COLS] = v & 255;
		end
	endtask

	task automatic fill_random();
		for (int r = 0; r < PAT_SIZE; r++)
			for (int c = 0; c < PAT_SIZE; c++) pat[r][c] = $random(seed) % 128;
		for (int r = 0; r < IMG_ROWS; r++)
			for (int c = 0; c < IMG_COLS; c++) img[r][c] = $random(seed) & 255;
	endtask

	task automatic load_pattern();
		for (int r = 0; r < PAT_SIZE; r++) begin
			for (int c = 0; c < PAT_SIZE; c++) begin
				@(posedge clk);
				#1;
				coef_wr = 1'b1;
				coef_row = tap_t'(r);
				coef_col = tap_t'(c);
				coef_data = coef_t'(pat[r][c]);
			end
		end
		@(posedge clk);
		#1;
		coef_wr = 1'b0;
	endtask

	task automatic send_pixels(input int max_gap, input int npix);
		int r;
		int c;
		int gap;
		for (int i = 0; i < npix; i++) begin
			r = i / IMG_COLS;
			c = i % IMG_COLS;
			@(posedge clk);
			#1;
			pix_valid = 1'b1;
			pix_data = pixel_t'(img[r][c]);
			if (r >= PAT_SIZE - 1 && c >= PAT_SIZE - 1) begin
				exp_score_q.push_back(window_score(r - PAT_SIZE + 1, c - PAT_SIZE + 1));
				exp_cycle_q.push_back(cyc + 3);     // the strobe is taken on the next edge
				exp_last_q.push_back(i == FRAME_PIX - 1);
			end
			gap = (max_gap > 0) ? (($random(seed) & 32'h7fff_ffff) % (max_gap + 1)) : 0;
			repeat (gap) begin
				@(posedge clk);
				#1;
				pix_valid = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		pix_valid = 1'b0;
	endtask

	task automatic run_case(input string name, input int max_gap, input int file_count,
			input bit use_file);
		int target;
		int err_start;
		int model;
		err_start = errors;
		target = frames_done + 1;
		model = model_count();
		load_pattern();
		send_pixels(max_gap, FRAME_PIX);
		wait (frames_done >= target);
		check_value("scores_per_frame", done_scores, WINDOWS_PER_FRAME);
		check_value("match_count", done_count, model);
		if (use_file) check_value("match_count_vs_file", done_count, file_count);
		cases_run++;
		$display("case %s: %0d detections, %0d errors", name, done_count, errors - err_start);
	endtask

	always @(negedge clk) begin
		if (cyc > 1 && rst_q) begin
			scores_seen = 0;
			first_score_seen = 1'b0;            // count must read zero again until a score
			check_value("score_valid", score_valid, 0);
			check_value("frame_done", frame_done, 0);
			check_value("match_count", match_count, 0);
		end else if (cyc > 1) begin
			if (score_valid === 1'b1) begin
				first_score_seen = 1'b1;
				if (exp_score_q.size() == 0) begin
					$display("error at %0t: a score came out with no window outstanding", $time);
					errors++;
				end else begin
					check_value("score", score, exp_score_q.pop_front());
					check_value("score_cycle", cyc, exp_cycle_q.pop_front());
					check_value("frame_done", frame_done, exp_last_q.pop_front());
					scores_seen++;
				end
				if (frame_done === 1'b1) begin
					done_scores = scores_seen;
					done_count = match_count;
					scores_seen = 0;
					frames_done++;
				end
			end else begin
				check_value("frame_done", frame_done, 0);
				if (!first_score_seen) check_value("match_count", match_count, 0);
			end
		end
	end

	initial begin
		int exp_count;
		bit ok;
		int n_cases;
		rst = 1'b1;
		pix_valid = 1'b0;
		pix_data = '0;
		coef_wr = 1'b0;
		coef_row = '0;
		coef_col = '0;
		coef_data = '0;
		seed = 32'hf66a_cfe8;
		n_cases = 0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (4) @(posedge clk);
		fd = $fopen("pattern_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open pattern_cases.txt");
			errors++;
		end else begin
			ok = 1'b1;
			while (ok && n_cases < MAX_FILE_CASES) begin
				read_case(exp_count, ok);
				if (ok) begin
					n_cases++;
					run_case($sformatf("file %0d", n_cases), 0, exp_count, 1'b1);
				end
			end
			$fclose(fd);
		end
		fill_random();
		run_case("random gaps", 2, 0, 1'b0);
		// cut a frame after a few windows and reset while the feeder is mid-frame
		fill_random();
		load_pattern();
		send_pixels(0, 70);
		while (exp_score_q.size() != 0) @(negedge clk);
		@(posedge clk);
		#1;
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		run_case("after reset", 0, 0, 1'b0);
		if (dut0.u_asserts.fail_count != 0) begin
			$display("%0d assertion failures in the protocol checks", dut0.u_asserts.fail_count);
			errors += dut0.u_asserts.fail_count;
		end
		$display("%0d cases, %0d checks, %0d errors", cases_run, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: window_feed.sv
module window_feed import pm_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic pix_valid,
	input  pixel_t pix_data,
	output logic win_valid,
	output logic win_last,
	output pixel_t [PAT_SIZE-1:0][PAT_SIZE-1:0] win_pix
);

	// win_pix[r][c] is the pixel in window row r and window column c,
	// with row 0 at the top and column 0 on the left

	col_t col;                                  // column of the incoming pixel
	row_t row;                                  // row of the incoming pixel
	logic last_col;
	logic last_row;
	logic win_done;

	// buffer 0 holds the line just above the current one, buffer 4 the oldest
	pixel_t line_buf [PAT_SIZE-1][IMG_COLS];

	pixel_t [PAT_SIZE-1:0] new_col;             // column entering the window on the right

	assign last_col = (col == col_t'(IMG_COLS - 1));
	assign last_row = (row == row_t'(IMG_ROWS - 1));

	// the incoming pixel is the bottom-right corner of a complete window
	assign win_done = (col >= col_t'(PAT_SIZE - 1)) && (row >= row_t'(PAT_SIZE - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
		end else if (pix_valid) begin
			if (last_col) begin
				col <= '0;
				if (last_row) begin
					row <= '0;                  // wrap to the start of the next frame
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// the window register is loaded on the same edge, so the tag lines up with win_pix
	always_ff @(posedge clk) begin
		if (rst) begin
			win_valid <= 1'b0;
			win_last <= 1'b0;
		end else begin
			win_valid <= pix_valid && win_done;
			win_last <= pix_valid && last_col && last_row;
		end
	end

	// bottom entry is the live pixel and the entries above come from older lines
	always_comb begin
		new_col[PAT_SIZE-1] = pix_data;
		for (int r = 0; r < PAT_SIZE - 1; r++) begin
			new_col[r] = line_buf[PAT_SIZE-2-r][col];
		end
	end

	// each pixel pushes the column below it one line deeper
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			line_buf[0][col] <= pix_data;
			for (int k = 1; k < PAT_SIZE - 1; k++) begin
				line_buf[k][col] <= line_buf[k-1][col];
			end
		end
	end

	// window slides one column left per accepted pixel
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			for (int r = 0; r < PAT_SIZE; r++) begin
				for (int c = 0; c < PAT_SIZE - 1; c++) begin
					win_pix[r][c] <= win_pix[r][c+1];
				end
				win_pix[r][PAT_SIZE-1] <= new_col[r];
			end
		end
	end

	// at the left edge of a row the window still holds columns of the row above,
	// but win_done keeps those windows from being reported

endmodule
